//--- files.f
common/playback_pkg.sv
common/sample_ram_if.sv
hw/sample_ram.sv
hw/ram_loader.sv
playback/stream_reader.sv
hw/playback_top.sv
test/playback_assertions.sv
test/playback_tb.sv

//--- Bender.yml
package:
  name: playback

sources:
  - common/playback_pkg.sv
  - common/sample_ram_if.sv
  - hw/sample_ram.sv
  - hw/ram_loader.sv
  - playback/stream_reader.sv
  - hw/playback_top.sv
  - target: test
    files:
      - test/playback_assertions.sv
      - test/playback_tb.sv

//--- test/playback_tb.sv
`default_nettype none

module playback_tb;
  import playback_pkg::*;

  logic              aclk;
  logic              aresetn;
  logic              wr_valid;
  logic [data_w-1:0] wr_data;
  logic              wr_restart;
  logic [addr_w-1:0] load_count;
  logic [addr_w-1:0] last_addr;
  play_mode_e        mode;
  logic              rewind;
  logic [data_w-1:0] m_tdata;
  logic              m_tvalid;
  logic              m_tready;
  logic              m_tlast;
  logic [addr_w-1:0] position;

  logic [data_w-1:0] model [depth];           // mirror of the sample ram
  int                model_ptr;               // mirror of load_count
  logic [31:0]       lfsr;
  int                errors;
  int                tests_passed;
  int                tests_failed;
  int                watchdog_cycles;
  int                stall_cycles;
  int                hold_errors;
  int                order_errors;            // position mismatches from skips or repeats
  int                n;
  int                m;
  int                err_mark;

  playback_top i_dut (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .wr_valid   (wr_valid),
    .wr_data    (wr_data),
    .wr_restart (wr_restart),
    .load_count (load_count),
    .last_addr  (last_addr),
    .mode       (mode),
    .rewind     (rewind),
    .m_tdata    (m_tdata),
    .m_tvalid   (m_tvalid),
    .m_tready   (m_tready),
    .m_tlast    (m_tlast),
    .position   (position)
  );

  initial aclk = 1'b0;
  always #4 aclk = ~aclk;

  // ========================================
  // helpers
  // ========================================
  // galois lfsr on x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int k);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < k; i++)
    begin
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
    errors++;
  endtask

  task automatic finish_test(input int num, input string name, input bit ok);
    if (ok)
    begin
      tests_passed++;
      $display("test %0d %s: passed", num, name);
    end
    else
    begin
      tests_failed++;
      $display("test %0d %s: failed", num, name);
    end
  endtask

  task automatic load_words(input int count);
    int i;
    for (i = 0; i < count; i++)
    begin
      @(negedge aclk);
      wr_valid         = 1'b1;
      wr_data          = rand_bits(data_w);
      model[model_ptr] = wr_data;
      model_ptr        = (model_ptr + 1) % depth;
    end
    @(negedge aclk);
    wr_valid = 1'b0;
    if (load_count !== model_ptr[addr_w-1:0]) report_mismatch("load_count", load_count, model_ptr);
  endtask

  task automatic rewind_reader(input logic [addr_w-1:0] last, input play_mode_e md);
    @(negedge aclk);
    m_tready  = 1'b0;
    last_addr = last;
    mode      = md;
    rewind    = 1'b1;
    @(negedge aclk);
    rewind = 1'b0;
    if (m_tvalid !== 1'b0)
    begin
      $display("m_tvalid still high in the cycle after rewind");
      errors++;
    end
    @(negedge aclk);
    if (last != 0 && m_tvalid !== 1'b1)
    begin
      $display("m_tvalid did not rise two edges after rewind");
      errors++;
    end
  endtask

  // transfers are seen at the falling edge before the rising edge that takes them
  task automatic play_words(input int count, input int words, input bit stall_mid);
    int                got;
    int                idx;
    int                stall_left;
    bit                stalled;
    logic [data_w-1:0] held_data;
    logic [addr_w-1:0] held_pos;
    got        = 0;
    stall_left = 0;
    stalled    = 1'b0;
    while (got < count)
    begin
      @(negedge aclk);
      if (stall_mid && got == count / 2 && stall_cycles == 0) stall_left = 4 + rand_bits(4);
      if (stall_left > 0)
      begin
        m_tready = 1'b0;                      // long back-pressure stretch
        stall_left--;
        stall_cycles++;
      end
      else
      begin
        m_tready = (rand_bits(2) != 0);       // ready three quarters of the time
      end
      if (stalled && m_tvalid)
      begin
        if (m_tdata !== held_data)
        begin
          report_mismatch("m_tdata held", m_tdata, held_data);
          hold_errors++;
        end
        if (position !== held_pos)
        begin
          report_mismatch("position held", position, held_pos);
          hold_errors++;
        end
      end
      if (m_tvalid && m_tready)
      begin
        idx = got % words;
        if (m_tdata !== model[idx]) report_mismatch("m_tdata", m_tdata, model[idx]);
        if (position !== idx[addr_w-1:0])
        begin
          report_mismatch("position", position, idx);
          order_errors++;
        end
        if (m_tlast !== (idx == words - 1)) report_mismatch("m_tlast", m_tlast, idx == words - 1);
        got++;
      end
      stalled   = m_tvalid && !m_tready;
      held_data = m_tdata;
      held_pos  = position;
    end
  endtask

  task automatic check_idle(input int cycles);
    m_tready = 1'b1;
    repeat (cycles)
    begin
      @(negedge aclk);
      if (m_tvalid !== 1'b0)
      begin
        $display("m_tvalid went high while the reader should stay idle");
        errors++;
      end
    end
  endtask

  // ========================================
  // watchdog
  // ========================================
  initial
  begin
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles) @(posedge aclk);
    $display("run timed out after %0d cycles", watchdog_cycles);
    $display("Test FAILED");
    $finish;
  end

  // ========================================
  // tests
  // ========================================
  initial
  begin
    lfsr            = 32'h2a43_4524;
    errors          = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    watchdog_cycles = 0;
    stall_cycles    = 0;
    hold_errors     = 0;
    order_errors    = 0;
    model_ptr       = 0;
    aresetn         = 1'b0;
    wr_valid        = 1'b0;
    wr_data         = '0;
    wr_restart      = 1'b0;
    last_addr       = '0;
    mode            = mode_stop;
    rewind          = 1'b0;
    m_tready        = 1'b0;

    n               = 2 + rand_bits(6) % 63;
    watchdog_cycles = (4 * n + (5 * n) / 2) * 8 + 1000;   // all words times 8 plus margin
    repeat (5) @(negedge aclk);
    aresetn = 1'b1;

    err_mark = errors;
    repeat (20)
    begin
      @(negedge aclk);
      if (m_tvalid !== 1'b0) report_mismatch("m_tvalid", m_tvalid, 0);
      if (m_tlast !== 1'b0) report_mismatch("m_tlast", m_tlast, 0);
      if (position !== '0) report_mismatch("position", position, 0);
      if (load_count !== '0) report_mismatch("load_count", load_count, 0);
    end
    finish_test(1, "reset state", errors == err_mark);

    err_mark = errors;
    load_words(n);
    rewind_reader(n - 1, mode_stop);
    play_words(n, n, 1'b1);
    check_idle(30);
    finish_test(2, "load and stop playback", errors == err_mark);
    finish_test(3, "back-pressure", stall_cycles > 0 && hold_errors == 0 && order_errors == 0);

    err_mark = errors;
    rewind_reader(n - 1, mode_wrap);
    play_words((5 * n) / 2, n, 1'b0);
    finish_test(4, "wrap mode", errors == err_mark);

    err_mark = errors;
    rewind_reader(0, mode_stop);              // park the reader before rewriting
    @(negedge aclk);
    wr_restart = 1'b1;
    @(negedge aclk);
    wr_restart = 1'b0;
    model_ptr  = 0;
    m          = 1 + rand_bits(6) % n;
    load_words(m);
    rewind_reader(n - 1, mode_stop);
    play_words(n, n, 1'b0);
    rewind_reader(0, mode_stop);
    check_idle(30);
    finish_test(5, "restart and rewrite", errors == err_mark);

    if (i_dut.i_reader.i_assertions.failures != 0)
    begin
      $display("%0d stream assertion failures", i_dut.i_reader.i_assertions.failures);
      errors++;
    end
    $display("tests passed %0d failed %0d, check errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/playback_assertions.sv
`default_nettype none

module playback_assertions (
  input logic                            aclk,
  input logic                            aresetn,
  input logic                            rewind,
  input logic                            tvalid,
  input logic                            tready,
  input logic [playback_pkg::data_w-1:0] tdata,
  input logic                            tlast
);

  int failures = 0;                           // read by the testbench at the end

  // a stalled word holds until it transfers or a rewind drops it
  assert property (@(posedge aclk) disable iff (!aresetn)
    (tvalid && !tready && !rewind) |=> (tvalid && $stable(tdata) && $stable(tlast)))
  else
  begin
    failures++;
    $error("stream word changed while stalled");
  end

  assert property (@(posedge aclk) disable iff (!aresetn) tlast |-> tvalid)
  else
  begin
    failures++;
    $error("tlast high without tvalid");
  end

  assert property (@(posedge aclk) $rose(aresetn) |=> !tvalid)
  else
  begin
    failures++;
    $error("tvalid high right after reset release");
  end

endmodule

bind stream_reader playback_assertions i_assertions (
  .aclk    (aclk),
  .aresetn (aresetn),
  .rewind  (rewind),
  .tvalid  (tvalid),
  .tready  (tready),
  .tdata   (tdata),
  .tlast   (tlast)
);

`default_nettype wire

//--- hw/playback_top.sv
`default_nettype none

module playback_top (
  input  logic                            aclk,
  input  logic                            aresetn,

  // load port
  input  logic                            wr_valid,
  input  logic [playback_pkg::data_w-1:0] wr_data,
  input  logic                            wr_restart,
  output logic [playback_pkg::addr_w-1:0] load_count,

  // playback control
  input  logic [playback_pkg::addr_w-1:0] last_addr,
  input  playback_pkg::play_mode_e        mode,
  input  logic                            rewind,

  // stream master
  output logic [playback_pkg::data_w-1:0] m_tdata,
  output logic                            m_tvalid,
  input  logic                            m_tready,
  output logic                            m_tlast,
  output logic [playback_pkg::addr_w-1:0] position
);

  sample_ram_if ram_bus ();

  // ========================================
  // sample storage
  // ========================================
  sample_ram i_ram (
    .aclk (aclk),
    .ram  (ram_bus.memory)
  );

  // ========================================
  // host write side
  // ========================================
  ram_loader i_loader (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .wr_valid   (wr_valid),
    .wr_restart (wr_restart),
    .wr_data    (wr_data),
    .load_count (load_count),
    .ram        (ram_bus.loader)
  );

  // ========================================
  // playback side
  // ========================================
  stream_reader i_reader (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .last_addr (last_addr),
    .mode      (mode),
    .rewind    (rewind),
    .tready    (m_tready),
    .tdata     (m_tdata),
    .tvalid    (m_tvalid),
    .tlast     (m_tlast),
    .position  (position),
    .ram       (ram_bus.reader)
  );

endmodule

`default_nettype wire

//--- playback/stream_reader.sv
`default_nettype none

module stream_reader (
  input  logic                            aclk,
  input  logic                            aresetn,
  input  logic [playback_pkg::addr_w-1:0] last_addr,
  input  playback_pkg::play_mode_e        mode,
  input  logic                            rewind,
  input  logic                            tready,
  output logic [playback_pkg::data_w-1:0] tdata,
  output logic                            tvalid,
  output logic                            tlast,
  output logic [playback_pkg::addr_w-1:0] position,
  sample_ram_if.reader                    ram
);
  import playback_pkg::*;

  reader_state_e     state;
  reader_state_e     state_next;
  logic [addr_w-1:0] pos;
  logic [addr_w-1:0] pos_next;
  logic              below_last;
  logic              xfer;

  // ========================================
  // registers
  // ========================================
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      pos   <= '0;
      state <= st_idle;
    end
    else
    begin
      pos   <= pos_next;
      state <= state_next;
    end
  end

  assign below_last = pos < last_addr;
  assign xfer       = tready & (state == st_stream);

  // ========================================
  // next position and state
  // ========================================
  always_comb
  begin
    pos_next   = pos;
    state_next = state;

    if ((state == st_idle) && below_last)
    begin
      state_next = st_stream;                 // arm when words remain
    end

    if (xfer)
    begin
      if (below_last)
      begin
        pos_next = pos + 1'b1;
      end
      else if (mode == mode_wrap)
      begin
        pos_next = '0;                        // loop, stream keeps going
      end
      else
      begin
        state_next = st_idle;                 // stop mode, p holds
      end
    end

    if (rewind)
    begin
      pos_next   = '0;                        // overrides everything above
      state_next = st_idle;
    end
  end

  // ========================================
  // ram look-ahead and stream outputs
  // ========================================
  // next position goes to the ram so rdata lines up with pos
  assign ram.raddr = pos_next;

  assign tdata    = ram.rdata;
  assign tvalid   = (state == st_stream);
  assign tlast    = (state == st_stream) & ~below_last;
  assign position = pos;

endmodule

`default_nettype wire

//--- hw/ram_loader.sv
`default_nettype none

module ram_loader (
  input  logic                            aclk,
  input  logic                            aresetn,
  input  logic                            wr_valid,
  input  logic                            wr_restart,
  input  logic [playback_pkg::data_w-1:0] wr_data,
  output logic [playback_pkg::addr_w-1:0] load_count,
  sample_ram_if.loader                    ram
);
  import playback_pkg::*;

  logic [addr_w-1:0] wr_ptr;
  logic              wr_fire;

  assign wr_fire = wr_valid & ~wr_restart;     // restart wins

  // pointer wraps at depth on its own width
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr <= '0;
    end
    else if (wr_restart)
    begin
      wr_ptr <= '0;
    end
    else if (wr_valid)
    begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // write goes out on the same edge as the strobe
  assign ram.we    = wr_fire;
  assign ram.waddr = wr_ptr;
  assign ram.wdata = wr_data;

  assign load_count = wr_ptr;                 // host reads this for last_addr

endmodule

`default_nettype wire

//--- hw/sample_ram.sv
`default_nettype none

module sample_ram (
  input  logic         aclk,
  sample_ram_if.memory ram
);
  import playback_pkg::*;

  logic [data_w-1:0] mem [depth];             // block ram, no reset

  // ========================================
  // write port
  // ========================================
  always_ff @(posedge aclk)
  begin
    if (ram.we)
    begin
      mem[ram.waddr] <= ram.wdata;
    end
  end

  // ========================================
  // read port
  // ========================================
  // read before write on a shared address, the old word comes out
  always_ff @(posedge aclk)
  begin
    ram.rdata <= mem[ram.raddr];
  end

endmodule

`default_nettype wire

//--- common/sample_ram_if.sv
`default_nettype none

interface sample_ram_if;
  import playback_pkg::*;

  // write side, from the loader
  logic              we;
  logic [addr_w-1:0] waddr;
  logic [data_w-1:0] wdata;

  // read side, address from the reader
  logic [addr_w-1:0] raddr;
  logic [data_w-1:0] rdata;                   // registered in the ram

  modport loader (
    output we, waddr, wdata
  );

  modport reader (
    output raddr,
    input  rdata
  );

  modport memory (
    input  we, waddr, wdata, raddr,
    output rdata
  );

endinterface

`default_nettype wire

//--- common/playback_pkg.sv
`default_nettype none

package playback_pkg;

  // ========================================
  // sizes
  // ========================================
  localparam int data_w = 32;                 // sample width
  localparam int addr_w = 10;                 // ram address width
  localparam int depth  = 1 << addr_w;        // 1024 words

  // ========================================
  // enums
  // ========================================
  typedef enum logic {
    mode_stop = 1'b0,                         // halt after the last word
    mode_wrap = 1'b1                          // loop back to address 0
  } play_mode_e;

  typedef enum logic {
    st_idle   = 1'b0,
    st_stream = 1'b1                          // tvalid asserted
  } reader_state_e;

endpackage

`default_nettype wire
